// File: design/alu_settings.svh
// ALU execution unit settings
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Data path width in bits, RV32I.
`define XLEN 32

// Width of the instruction id that travels with each issue.
// Sized for up to eight instructions in flight downstream.
`define ID_WIDTH 3

// Width of a shift amount field.
`define SHAMT_WIDTH 5

// Bit position of funct7[5] inside the I-type immediate.
// Marks SRAI against SRLI.
`define IMM_ALT_BIT 10

`endif

// File: design/riscv_types_pkg.sv
// RV32I encoding types
`default_nettype none

`include "alu_settings.svh"

package riscv_types_pkg;

    // Operand and result word.
    typedef logic [`XLEN-1:0] data_t;

    // Shift amount, low bits of the second operand.
    typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

    // Major opcodes handled by the ALU.
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011, // Register-register ops.
        OP_IMM = 7'b0010011  // Register-immediate ops.
    } opcode_t;

    // funct3 field for the OP and OP-IMM groups.
    typedef enum logic [2:0] {
        FN3_ADD  = 3'b000, // ADD, SUB, ADDI.
        FN3_SLL  = 3'b001,
        FN3_SLT  = 3'b010,
        FN3_SLTU = 3'b011,
        FN3_XOR  = 3'b100,
        FN3_SR   = 3'b101, // SRL or SRA, picked by funct7[5].
        FN3_OR   = 3'b110,
        FN3_AND  = 3'b111
    } funct3_t;

endpackage

`default_nettype wire

// File: design/alu_types_pkg.sv
// ALU control types
`default_nettype none

`include "alu_settings.svh"

package alu_types_pkg;

    // Operation applied ahead of the adder.
    // Logic results ride the carry chain with a zero second operand.
    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11 // Add, subtract and compare.
    } logic_op_t;

    // Instruction id carried to writeback.
    typedef logic [`ID_WIDTH-1:0] id_t;

    // Adder operand with one extension bit on top.
    // The top bit of the sum gives the SLT and SLTU answer.
    typedef logic [`XLEN:0] adder_word_t;

endpackage

`default_nettype wire

// File: design/alu_decode.sv
// ALU decode
// Instruction fields to ALU controls and adder operands
`default_nettype none

`include "alu_settings.svh"

module alu_decode
    import riscv_types_pkg::*, alu_types_pkg::*;
(
    input  opcode_t     opcode,
    input  funct3_t     funct3,
    input  logic        alt,          // funct7[5].
    input  data_t       rs1_value,
    input  data_t       rs2_value,
    input  data_t       imm_value,
    output logic_op_t   logic_op,
    output logic        subtract,
    output adder_word_t adder_in1,
    output adder_word_t adder_in2,
    output logic        shifter_path,
    output logic        slt_path,
    output data_t       shifter_in,
    output shamt_t      shift_amount,
    output logic        arith,
    output logic        lshift
);

    data_t operand2;   // Register or immediate second operand.
    logic  is_sub;     // Register form SUB.
    logic  is_slt;
    logic  is_sltu;
    logic  sign_ext;   // Extend operands with their sign bit.

    // OP-IMM takes the immediate, OP takes rs2.
    assign operand2 = (opcode == OP_IMM) ? imm_value : rs2_value;

    // ADDI has no subtract form, the alt bit there is part of the immediate.
    assign is_sub  = (funct3 == FN3_ADD) && (opcode == OP_REG) && alt;
    assign is_slt  = (funct3 == FN3_SLT);
    assign is_sltu = (funct3 == FN3_SLTU);

    // Compares are subtractions, only the top bit of the sum is kept.
    assign subtract = is_sub | is_slt | is_sltu;
    assign slt_path = is_slt | is_sltu;

    // Logic op select.
    always_comb begin
        case (funct3)
            FN3_XOR: logic_op = ALU_LOGIC_XOR;
            FN3_OR:  logic_op = ALU_LOGIC_OR;
            FN3_AND: logic_op = ALU_LOGIC_AND;
            default: logic_op = ALU_LOGIC_ADD; // Add, sub, compares, shifts.
        endcase
    end

    // Unsigned compare zero-extends, so the top sum bit is the borrow.
    // Signed ops sign-extend, so the top sum bit is the true sign.
    assign sign_ext = ~is_sltu;

    assign adder_in1 = {sign_ext & rs1_value[`XLEN-1], rs1_value};
    assign adder_in2 = {sign_ext & operand2[`XLEN-1], operand2};

    // Shifter controls.
    assign shifter_path = (funct3 == FN3_SLL) || (funct3 == FN3_SR);
    assign shifter_in   = rs1_value;
    assign shift_amount = operand2[`SHAMT_WIDTH-1:0]; // Upper bits ignored.
    assign arith        = (funct3 == FN3_SR) && alt;  // SRA, SRAI.
    assign lshift       = (funct3 == FN3_SLL);

endmodule

`default_nettype wire

// File: design/barrel_shifter.sv
// Barrel shifter
`default_nettype none

`include "alu_settings.svh"

module barrel_shifter
    import riscv_types_pkg::*;
(
    input  data_t  shifter_input,
    input  shamt_t shift_amount,
    input  logic   arith,          // Fill with the sign bit.
    input  logic   lshift,         // Shift left.
    output data_t  shifted_result
);

    data_t                shift_source;  // Input, reversed for left shifts.
    logic                 fill_bit;
    logic signed [`XLEN:0] extended;     // Fill bit above the data.
    logic signed [`XLEN:0] shifted_wide;

    // Mirror a word end to end.
    function automatic data_t bit_reverse(input data_t word);
        data_t flipped;
        for (int i = 0; i < `XLEN; i++) begin
            flipped[i] = word[`XLEN-1-i];
        end
        return flipped;
    endfunction

    // A left shift is a right shift of the mirrored word.
    assign shift_source = lshift ? bit_reverse(shifter_input) : shifter_input;

    // Logical shifts and left shifts fill with zero.
    assign fill_bit = arith & shifter_input[`XLEN-1];
    assign extended = {fill_bit, shift_source};

    // One arithmetic right shift covers all three cases.
    assign shifted_wide = extended >>> shift_amount;

    // Mirror back after a left shift.
    assign shifted_result = lshift ? bit_reverse(shifted_wide[`XLEN-1:0])
                                   : shifted_wide[`XLEN-1:0];

endmodule

`default_nettype wire

// File: design/alu_unit.sv
// ALU adder, result select and writeback
`default_nettype none

`include "alu_settings.svh"

module alu_unit
    import riscv_types_pkg::*, alu_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue_valid,
    input  id_t         instruction_id,
    input  logic_op_t   logic_op,
    input  logic        subtract,
    input  adder_word_t adder_in1,
    input  adder_word_t adder_in2,
    input  logic        shifter_path,
    input  logic        slt_path,
    input  data_t       shift_result,
    output logic        wb_done,
    output id_t         wb_id,
    output data_t       wb_rd
);

    adder_word_t         operand_a;      // Logic result or first addend.
    adder_word_t         operand_b;      // Second addend, zero for logic ops.
    logic [`XLEN+1:0]    wide_sum;       // Carry-in slot in bit 0.
    adder_word_t         add_sub_result;
    data_t               result;

    // Logic ops go through the adder with nothing added.
    always_comb begin
        case (logic_op)
            ALU_LOGIC_XOR: operand_a = adder_in1 ^ adder_in2;
            ALU_LOGIC_OR:  operand_a = adder_in1 | adder_in2;
            ALU_LOGIC_AND: operand_a = adder_in1 & adder_in2;
            default:       operand_a = adder_in1;
        endcase
        if (logic_op == ALU_LOGIC_ADD) begin
            operand_b = adder_in2 ^ {(`XLEN+1){subtract}}; // One's complement on subtract.
        end else begin
            operand_b = '0;
        end
    end

    // Subtract bit in the low slot of both operands gives the +1 carry-in.
    assign wide_sum       = {operand_a, subtract} + {operand_b, subtract};
    assign add_sub_result = wide_sum[`XLEN+1:1];

    // Result select.
    always_comb begin
        result = shifter_path ? shift_result : add_sub_result[`XLEN-1:0];
        if (slt_path) begin
            result = {{(`XLEN-1){1'b0}}, add_sub_result[`XLEN]}; // Sign or borrow.
        end
    end

    // Done strobe and result, one cycle after issue.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_done <= 1'b0;
            wb_rd   <= '0;
        end else begin
            wb_done <= issue_valid;
            if (issue_valid) begin
                wb_rd <= result; // Holds while idle.
            end
        end
    end

    // Id follows the result.
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            wb_id <= instruction_id;
        end
    end

endmodule

`default_nettype wire

// File: design/alu_exec.sv
// ALU execution unit top level
`default_nettype none

module alu_exec
    import riscv_types_pkg::*, alu_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue_valid,     // One strobe per instruction.
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  logic    alt,             // funct7[5].
    input  data_t   rs1_value,
    input  data_t   rs2_value,
    input  data_t   imm_value,
    input  id_t     instruction_id,
    output logic    wb_done,
    output id_t     wb_id,
    output data_t   wb_rd
);

    logic_op_t   logic_op;
    logic        subtract;
    adder_word_t adder_in1;
    adder_word_t adder_in2;
    logic        shifter_path;
    logic        slt_path;
    data_t       shifter_in;
    shamt_t      shift_amount;
    logic        arith;
    logic        lshift;
    data_t       shift_result;

    alu_decode decode (
        .opcode       (opcode),
        .funct3       (funct3),
        .alt          (alt),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .imm_value    (imm_value),
        .logic_op     (logic_op),
        .subtract     (subtract),
        .adder_in1    (adder_in1),
        .adder_in2    (adder_in2),
        .shifter_path (shifter_path),
        .slt_path     (slt_path),
        .shifter_in   (shifter_in),
        .shift_amount (shift_amount),
        .arith        (arith),
        .lshift       (lshift)
    );

    barrel_shifter shifter (
        .shifter_input  (shifter_in),
        .shift_amount   (shift_amount),
        .arith          (arith),
        .lshift         (lshift),
        .shifted_result (shift_result)
    );

    alu_unit alu (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .instruction_id (instruction_id),
        .logic_op       (logic_op),
        .subtract       (subtract),
        .adder_in1      (adder_in1),
        .adder_in2      (adder_in2),
        .shifter_path   (shifter_path),
        .slt_path       (slt_path),
        .shift_result   (shift_result),
        .wb_done        (wb_done),
        .wb_id          (wb_id),
        .wb_rd          (wb_rd)
    );

endmodule

`default_nettype wire

// File: testbench/alu_exec_tb.sv
// ALU execution unit testbench
// Random issue stream checked against an RV32I reference model
`default_nettype none

`include "alu_settings.svh"

module alu_exec_tb
    import riscv_types_pkg::*, alu_types_pkg::*;
();

    localparam int          NUM_ISSUES  = 2000;
    localparam int          MAX_CYCLES  = 20000;        // Bound on the issue loop.
    localparam int          DRAIN_LIMIT = 8;            // Cycles allowed for the last writeback.
    localparam logic [31:0] SEED        = 32'hb16b_ae50;

    localparam data_t ALL_ONES  = '1;
    localparam data_t SIGN_ONLY = {1'b1, {(`XLEN-1){1'b0}}};

    logic    clk;
    logic    rst_n;
    logic    issue_valid;
    opcode_t opcode;
    funct3_t funct3;
    logic    alt;
    data_t   rs1_value;
    data_t   rs2_value;
    data_t   imm_value;
    id_t     instruction_id;
    logic    wb_done;
    id_t     wb_id;
    data_t   wb_rd;

    // Model state for the writeback due after the next edge.
    logic    exp_done;
    id_t     exp_id;
    data_t   exp_rd;          // Holds while idle, like the result register.
    string   exp_name;

    logic [31:0] rng_state;
    id_t         next_id;
    int          issued;
    int          checked;     // Writebacks compared with the model.
    int          cycles;
    int          drain_cycles;
    int          mismatch_count;
    int          timeout_count;

    alu_exec dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .opcode         (opcode),
        .funct3         (funct3),
        .alt            (alt),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .imm_value      (imm_value),
        .instruction_id (instruction_id),
        .wb_done        (wb_done),
        .wb_id          (wb_id),
        .wb_rd          (wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Register operand, biased toward edge values.
    function automatic data_t pick_register_value();
        logic [31:0] r;
        r = next_random();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return ALL_ONES;
            3'd2:    return SIGN_ONLY;
            3'd3:    return ~SIGN_ONLY;   // Largest positive.
            3'd4:    return data_t'(1);
            default: return next_random();
        endcase
    endfunction

    // I-type immediate, 12 bits sign-extended.
    function automatic data_t pick_immediate();
        logic [31:0] r;
        logic [11:0] imm12;
        r = next_random();
        case (r[2:0])
            3'd0:    imm12 = 12'h000;
            3'd1:    imm12 = 12'hfff;     // Minus one.
            3'd2:    imm12 = 12'h800;     // Most negative.
            3'd3:    imm12 = 12'h7ff;
            default: imm12 = r[31:20];
        endcase
        return {{(`XLEN-12){imm12[11]}}, imm12};
    endfunction

    // Shift immediates carry funct7 in imm[11:5] and shamt in imm[4:0].
    function automatic data_t shift_immediate(input logic arith_shift);
        logic [31:0] r;
        logic [4:0]  shamt;
        r = next_random();
        case (r[1:0])
            2'd0:    shamt = 5'd0;
            2'd1:    shamt = 5'd31;
            default: shamt = r[12:8];
        endcase
        return {{(`XLEN-12){1'b0}}, 1'b0, arith_shift, 5'b00000, shamt};
    endfunction

    // Reference result from the RV32I definition.
    function automatic data_t expected_result(input opcode_t op, input funct3_t f,
                                              input logic alt_bit, input data_t a,
                                              input data_t b);
        logic signed [`XLEN-1:0] sa;
        logic signed [`XLEN-1:0] sb;
        logic [4:0]              sh;
        sa = a;
        sb = b;
        sh = b[4:0];                      // Only the low five bits count.
        case (f)
            FN3_ADD:  return (op == OP_REG && alt_bit) ? a - b : a + b;
            FN3_SLL:  return a << sh;
            FN3_SLT:  return (sa < sb) ? data_t'(1) : data_t'(0);
            FN3_SLTU: return (a < b) ? data_t'(1) : data_t'(0);
            FN3_XOR:  return a ^ b;
            FN3_SR:   return alt_bit ? data_t'(sa >>> sh) : a >> sh;
            FN3_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // Mnemonic used as the test name in error lines.
    function automatic string op_name(input opcode_t op, input funct3_t f,
                                      input logic alt_bit);
        string base;
        case (f)
            FN3_ADD:  base = (op == OP_REG && alt_bit) ? "SUB" : "ADD";
            FN3_SLL:  base = "SLL";
            FN3_SLT:  base = "SLT";
            FN3_SLTU: base = "SLTU";
            FN3_XOR:  base = "XOR";
            FN3_SR:   base = alt_bit ? "SRA" : "SRL";
            FN3_OR:   base = "OR";
            default:  base = "AND";
        endcase
        if (op == OP_IMM) begin
            if (f == FN3_SLTU) begin
                return "SLTIU";
            end
            return {base, "I"};
        end
        return base;
    endfunction

    // Compare the writeback outputs with the model entry.
    task automatic check_writeback();
        assert (wb_done === exp_done) else begin
            $display("MISMATCH %s wb_done: expected %0b, actual %0b",
                     exp_name, exp_done, wb_done);
            mismatch_count++;
        end
        if (exp_done) begin
            checked++;
            assert (wb_id === exp_id) else begin
                $display("MISMATCH %s wb_id: expected %0d, actual %0d",
                         exp_name, exp_id, wb_id);
                mismatch_count++;
            end
        end
        assert (wb_rd === exp_rd) else begin
            $display("MISMATCH %s wb_rd: expected %h, actual %h", exp_name, exp_rd, wb_rd);
            mismatch_count++;
        end
    endtask

    // One cycle of stimulus, and the model entry it produces.
    task automatic drive_next();
        logic [31:0] r;
        data_t       operand2;
        r      = next_random();
        opcode = r[8] ? OP_REG : OP_IMM;
        funct3 = funct3_t'(r[6:4]);
        rs2_value = pick_register_value();
        if (opcode == OP_IMM) begin
            if (funct3 == FN3_SLL || funct3 == FN3_SR) begin
                alt       = (funct3 == FN3_SR) && r[9];
                imm_value = shift_immediate(alt);
            end else begin
                imm_value = pick_immediate();
                alt       = imm_value[`IMM_ALT_BIT]; // Bit 30 of the word, no SUBI.
            end
            operand2 = imm_value;
        end else begin
            imm_value = pick_immediate(); // Not used by register forms.
            alt       = (funct3 == FN3_ADD || funct3 == FN3_SR) && r[9];
            operand2  = rs2_value;
        end
        if (r[12:10] == 3'b000) begin
            rs1_value = operand2;         // Equal pair.
        end else begin
            rs1_value = pick_register_value();
        end
        issue_valid    = (r[1:0] != 2'b00);
        instruction_id = next_id;
        if (issue_valid) begin
            exp_done = 1'b1;
            exp_id   = next_id;
            exp_rd   = expected_result(opcode, funct3, alt, rs1_value, operand2);
            exp_name = op_name(opcode, funct3, alt);
            next_id++;
            issued++;
        end else begin
            exp_done = 1'b0;              // Result register keeps its value.
            exp_name = "idle";
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        issue_valid    = 1'b0;
        opcode         = OP_REG;
        funct3         = FN3_ADD;
        alt            = 1'b0;
        rs1_value      = '0;
        rs2_value      = '0;
        imm_value      = '0;
        instruction_id = '0;
        rng_state      = SEED;
        next_id        = '0;
        issued         = 0;
        checked        = 0;
        cycles         = 0;
        drain_cycles   = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        exp_done       = 1'b0;
        exp_id         = '0;
        exp_rd         = '0;
        exp_name       = "reset";

        // Outputs stay cleared through reset.
        repeat (2) begin
            @(posedge clk);
            #1;
            check_writeback();
        end
        rst_n    = 1'b1;
        exp_name = "after reset";

        while (issued < NUM_ISSUES && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #1;
            check_writeback();            // Entry from the previous cycle.
            drive_next();
            cycles++;
        end
        if (issued < NUM_ISSUES) begin
            $display("Timeout: only %0d of %0d instructions issued in %0d cycles",
                     issued, NUM_ISSUES, cycles);
            timeout_count++;
        end

        // Last writeback of the stream.
        if (exp_done) begin
            do begin
                @(posedge clk);
                #1;
                issue_valid = 1'b0;
                drain_cycles++;
            end while (!wb_done && drain_cycles < DRAIN_LIMIT);
            if (!wb_done) begin
                $display("Timeout: no writeback for the last instruction after %0d cycles",
                         drain_cycles);
                timeout_count++;
            end else begin
                assert (drain_cycles == 1) else begin
                    $display("Last writeback came %0d cycles after its issue instead of 1",
                             drain_cycles);
                    mismatch_count++;
                end
                check_writeback();
            end
        end

        assert (checked == NUM_ISSUES) else begin
            $display("Only %0d of %0d writebacks were checked", checked, NUM_ISSUES);
            mismatch_count++;
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d writebacks checked",
                 mismatch_count, timeout_count, checked);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/riscv_types_pkg.sv
design/alu_types_pkg.sv
design/alu_decode.sv
design/barrel_shifter.sv
design/alu_unit.sv
design/alu_exec.sv
testbench/alu_exec_tb.sv

// File: Makefile
TOP = alu_exec_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
